/* src/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 64;
    localparam logic [xlen-1:0] reset_pc = 64'h8000_0000;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_imm32  = 7'b0011011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_reg32  = 7'b0111011;

    // low bit of each instruction field
    localparam int rd_lo  = 7;
    localparam int f3_lo  = 12;
    localparam int rs1_lo = 15;
    localparam int rs2_lo = 20;
    localparam int f7_lo  = 25;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui, alu_mulw, alu_divw, alu_remw
    } alu_op_e;

    typedef enum logic [1:0] {src1_rs1, src1_pc, src1_rs1w} src1_e;
    typedef enum logic [1:0] {src2_rs2, src2_imm, src2_four, src2_rs2w} src2_e;

    // nine kinds, so four bits
    typedef enum logic [3:0] {
        br_none, br_jal, br_jalr, br_eq, br_ne, br_lt, br_ltu, br_ge, br_geu
    } br_e;

    typedef enum logic [1:0] {sz_byte, sz_half, sz_word, sz_double} mem_size_e;

    typedef struct packed {
        alu_op_e   alu_op;
        src1_e     src1;
        src2_e     src2;
        br_e       br;
        logic      rf_we;
        logic [4:0] rd;
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      mem_unsigned;
        logic      word;      // sign-extend low 32 bits of result
        logic      illegal;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] alu_res;
        logic            br_taken;
        logic [xlen-1:0] target;
        logic [xlen-1:0] store_data;
    } exec_t;

endpackage

/* src/rv_decode.sv */
`timescale 1ns/10ps

module rv_decode import rv_pkg::*; (
    input  logic [31:0]     inst,
    output ctrl_t           ctrl,
    output logic [xlen-1:0] imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_jal;
    logic       is_jalr;
    logic       r_type;
    logic       b_type;
    logic       load;
    logic       store;
    logic       imm_ok;
    logic       divrem;
    logic       r32_ok;
    logic       word;
    logic       legal;

    assign opcode = inst[6:0];
    assign funct3 = inst[f3_lo +: 3];
    assign funct7 = inst[f7_lo +: 7];

    // instruction classes
    assign is_jal  = opcode == op_jal;
    assign is_jalr = opcode == op_jalr && funct3 == 3'b000;
    assign r_type  = opcode == op_reg && (funct7 == 7'b0000000 ||
                     (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
    assign b_type  = opcode == op_branch && funct3[2:1] != 2'b01;
    assign load    = opcode == op_load && funct3 != 3'b111;
    assign store   = opcode == op_store && !funct3[2];
    assign imm_ok  = opcode == op_imm && (funct3 inside {3'b000, 3'b011, 3'b111} ||
                     (funct3 == 3'b001 && funct7[6:1] == 6'b000000) ||
                     (funct3 == 3'b101 && (funct7[6:1] == 6'b000000 ||
                                           funct7[6:1] == 6'b010000)));
    assign divrem  = opcode == op_reg32 && funct7 == 7'b0000001 &&
                     (funct3 == 3'b100 || funct3 == 3'b110);
    assign r32_ok  = opcode == op_reg32 && (divrem || (funct3 == 3'b000 &&
                     funct7 inside {7'b0000000, 7'b0100000, 7'b0000001}));
    assign word    = (opcode == op_imm32 && funct3 == 3'b000) || r32_ok;

    assign legal = opcode == op_lui || opcode == op_auipc || is_jal || is_jalr ||
                   b_type || load || store || imm_ok || r_type || word;

    always_comb begin
        ctrl = '0;
        ctrl.illegal      = !legal;
        ctrl.rf_we        = !ctrl.illegal && !b_type && !store;
        ctrl.rd           = inst[rd_lo +: 5];
        ctrl.mem_read     = load;
        ctrl.mem_write    = store;
        ctrl.mem_size     = mem_size_e'(funct3[1:0]);
        ctrl.mem_unsigned = funct3[2];
        ctrl.word         = word;

        case (opcode)
            op_lui: ctrl.alu_op = alu_lui;
            op_reg, op_imm: begin
                case (funct3)
                    3'b000: ctrl.alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
                    3'b001: ctrl.alu_op = alu_sll;
                    3'b010: ctrl.alu_op = alu_slt;
                    3'b011: ctrl.alu_op = alu_sltu;
                    3'b100: ctrl.alu_op = alu_xor;
                    3'b101: ctrl.alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110: ctrl.alu_op = alu_or;
                    default: ctrl.alu_op = alu_and;
                endcase
            end
            op_reg32: begin
                if (divrem)
                    ctrl.alu_op = funct3[1] ? alu_remw : alu_divw;
                else if (funct7[0])
                    ctrl.alu_op = alu_mulw;
                else
                    ctrl.alu_op = funct7[5] ? alu_sub : alu_add;
            end
            default: ctrl.alu_op = alu_add;   // address, link and auipc sums
        endcase

        if (opcode == op_auipc || is_jal || is_jalr)
            ctrl.src1 = src1_pc;
        else if (divrem)
            ctrl.src1 = src1_rs1w;

        if (is_jal || is_jalr)
            ctrl.src2 = src2_four;            // link value pc+4
        else if (divrem)
            ctrl.src2 = src2_rs2w;
        else if (opcode == op_lui || opcode == op_auipc || load || store ||
                 opcode == op_imm || opcode == op_imm32)
            ctrl.src2 = src2_imm;

        if (is_jal)
            ctrl.br = br_jal;
        else if (is_jalr)
            ctrl.br = br_jalr;
        else if (b_type) begin
            case (funct3)
                3'b000: ctrl.br = br_eq;
                3'b001: ctrl.br = br_ne;
                3'b100: ctrl.br = br_lt;
                3'b101: ctrl.br = br_ge;
                3'b110: ctrl.br = br_ltu;
                default: ctrl.br = br_geu;
            endcase
        end
    end

    // immediate by format
    always_comb begin
        case (opcode)
            op_store:         imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
            op_branch:        imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25],
                                     inst[11:8], 1'b0};
            op_lui, op_auipc: imm = {{32{inst[31]}}, inst[31:12], 12'b0};
            op_jal:           imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20],
                                     inst[30:21], 1'b0};
            default:          imm = {{52{inst[31]}}, inst[31:20]};
        endcase
    end

endmodule

/* src/rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2,
    input  logic            we,
    input  logic [4:0]      rd,
    input  logic [xlen-1:0] wdata
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 hardwired
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* src/rv_execute.sv */
`timescale 1ns/10ps

module rv_execute import rv_pkg::*; (
    input  ctrl_t           ctrl,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rdata1,
    input  logic [xlen-1:0] rdata2,
    input  logic            inst_valid,
    output exec_t           ex,
    output logic            mem_ena,
    output logic            mem_wen,
    output mem_size_e       mem_size
);

    logic [xlen-1:0]   a;
    logic [xlen-1:0]   b;
    logic [xlen-1:0]   sum;
    logic [xlen-1:0]   diff;
    logic              lt;
    logic              ltu;
    logic [5:0]        shamt;
    logic [31:0]       mul32;
    logic signed [31:0] a32;
    logic signed [31:0] b32;
    logic signed [31:0] quot;
    logic signed [31:0] rem;
    logic [xlen-1:0]   res;

    always_comb begin
        case (ctrl.src1)
            src1_pc:   a = pc;
            src1_rs1w: a = {32'b0, rdata1[31:0]};
            default:   a = rdata1;
        endcase
        case (ctrl.src2)
            src2_imm:  b = imm;
            src2_four: b = 64'd4;
            src2_rs2w: b = {32'b0, rdata2[31:0]};
            default:   b = rdata2;
        endcase
    end

    assign sum   = a + b;
    assign diff  = a - b;
    assign lt    = $signed(a) < $signed(b);
    assign ltu   = a < b;
    assign shamt = b[5:0];
    assign mul32 = a[31:0] * b[31:0];   // low word only
    assign a32   = a[31:0];
    assign b32   = b[31:0];

    // riscv div by zero and overflow cases
    always_comb begin
        if (b32 == 32'sd0) begin
            quot = -32'sd1;
            rem  = a32;
        end else if (a32 == 32'sh8000_0000 && b32 == -32'sd1) begin
            quot = a32;
            rem  = 32'sd0;
        end else begin
            quot = a32 / b32;
            rem  = a32 % b32;
        end
    end

    always_comb begin
        case (ctrl.alu_op)
            alu_sub:  res = diff;
            alu_slt:  res = {63'b0, lt};
            alu_sltu: res = {63'b0, ltu};
            alu_and:  res = a & b;
            alu_or:   res = a | b;
            alu_xor:  res = a ^ b;
            alu_sll:  res = a << shamt;
            alu_srl:  res = a >> shamt;
            alu_sra:  res = $signed(a) >>> shamt;
            alu_lui:  res = b;
            alu_mulw: res = {32'b0, mul32};
            alu_divw: res = {32'b0, quot};
            alu_remw: res = {32'b0, rem};
            default:  res = sum;
        endcase
    end

    assign ex.alu_res = ctrl.word ? {{32{res[31]}}, res[31:0]} : res;

    // compare reuses sub and slt results
    always_comb begin
        case (ctrl.br)
            br_jal, br_jalr: ex.br_taken = 1'b1;
            br_eq:   ex.br_taken = diff == '0;
            br_ne:   ex.br_taken = diff != '0;
            br_lt:   ex.br_taken = lt;
            br_ltu:  ex.br_taken = ltu;
            br_ge:   ex.br_taken = !lt;
            br_geu:  ex.br_taken = !ltu;
            default: ex.br_taken = 1'b0;
        endcase
    end

    assign ex.target = (ctrl.br == br_jalr) ? ((rdata1 + imm) & ~64'd1) : pc + imm;
    assign ex.store_data = rdata2;

    assign mem_ena  = (ctrl.mem_read || ctrl.mem_write) && inst_valid;
    assign mem_wen  = ctrl.mem_write && inst_valid;
    assign mem_size = ctrl.mem_size;

endmodule

/* src/rv_result.sv */
`timescale 1ns/10ps

module rv_result import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            inst_valid,
    input  ctrl_t           ctrl,
    input  exec_t           ex,
    input  logic [xlen-1:0] mem_rdata,
    output logic [xlen-1:0] pc,
    output logic            wb_en,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_data
);

    logic [xlen-1:0] load_data;
    logic [xlen-1:0] next_pc;

    // addressed bytes sit in the low end of rdata
    always_comb begin
        case (ctrl.mem_size)
            sz_byte: load_data = ctrl.mem_unsigned ? {56'b0, mem_rdata[7:0]}
                                                   : {{56{mem_rdata[7]}}, mem_rdata[7:0]};
            sz_half: load_data = ctrl.mem_unsigned ? {48'b0, mem_rdata[15:0]}
                                                   : {{48{mem_rdata[15]}}, mem_rdata[15:0]};
            sz_word: load_data = ctrl.mem_unsigned ? {32'b0, mem_rdata[31:0]}
                                                   : {{32{mem_rdata[31]}}, mem_rdata[31:0]};
            default: load_data = mem_rdata;
        endcase
    end

    assign wb_data = ctrl.mem_read ? load_data : ex.alu_res;  // jal/jalr carry pc+4
    assign wb_en   = ctrl.rf_we && inst_valid;
    assign wb_rd   = ctrl.rd;

    assign next_pc = ex.br_taken ? ex.target : pc + 64'd4;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= reset_pc;
        else if (inst_valid)
            pc <= next_pc;
    end

endmodule

/* src/rv_core.sv */
`timescale 1ns/10ps

module rv_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [31:0]     inst,
    input  logic            inst_valid,
    output logic            mem_ena,
    output logic            mem_wen,
    output logic [xlen-1:0] mem_addr,
    output logic [xlen-1:0] mem_wdata,
    output mem_size_e       mem_size,
    input  logic [xlen-1:0] mem_rdata,
    output logic [xlen-1:0] pc,
    output logic            wb_en,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_data,
    output logic            illegal
);

    ctrl_t           ctrl;
    exec_t           ex;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;

    rv_decode u_decode (
        .inst (inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .rs1    (inst[rs1_lo +: 5]),
        .rs2    (inst[rs2_lo +: 5]),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (wb_en),
        .rd     (wb_rd),
        .wdata  (wb_data)
    );

    rv_execute u_execute (
        .ctrl       (ctrl),
        .imm        (imm),
        .pc         (pc),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .inst_valid (inst_valid),
        .ex         (ex),
        .mem_ena    (mem_ena),
        .mem_wen    (mem_wen),
        .mem_size   (mem_size)
    );

    rv_result u_result (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .ctrl       (ctrl),
        .ex         (ex),
        .mem_rdata  (mem_rdata),
        .pc         (pc),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    assign mem_addr  = ex.alu_res;
    assign mem_wdata = ex.store_data;
    assign illegal   = ctrl.illegal;

endmodule

/* bench/rv_core_sva.sv */
`timescale 1ns/10ps

module rv_core_sva import rv_pkg::*; (
    input logic            clk,
    input logic            reset,
    input logic            inst_valid,
    input logic            wb_en,
    input logic            mem_ena,
    input logic            illegal,
    input logic [xlen-1:0] pc
);

    // nothing commits without a valid instruction
    a_gated: assert property (@(posedge clk) disable iff (reset)
        !inst_valid |-> !wb_en && !mem_ena)
        else $error("wb_en or mem_ena high without inst_valid");

    a_illegal: assert property (@(posedge clk) disable iff (reset)
        illegal |-> !wb_en && !mem_ena)
        else $error("illegal instruction writes or accesses memory");

    a_align: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    a_hold: assert property (@(posedge clk) disable iff (reset)
        !inst_valid |=> $stable(pc))
        else $error("pc moved in an idle cycle");

endmodule

bind rv_core rv_core_sva sva0 (.*);

/* bench/tb_core.sv */
`timescale 1ns/10ps

module tb_core import rv_pkg::*; ();

    localparam int n_alu   = 400;
    localparam int n_div   = 120;
    localparam int n_mem   = 300;
    localparam int n_ctrl  = 200;
    localparam int n_bad   = 150;
    localparam int total_insts = 31 + 1 + n_alu + 7 + n_div + n_mem + n_ctrl + n_bad;

    logic            clk;
    logic            reset;
    logic [31:0]     inst;
    logic            inst_valid;
    logic            mem_ena;
    logic            mem_wen;
    logic [63:0]     mem_addr;
    logic [63:0]     mem_wdata;
    mem_size_e       mem_size;
    logic [63:0]     mem_rdata;
    logic [63:0]     pc;
    logic            wb_en;
    logic [4:0]      wb_rd;
    logic [63:0]     wb_data;
    logic            illegal;

    // reference state
    logic [63:0] regs [32];
    logic [63:0] mpc;
    logic [7:0]  mem [logic [63:0]];
    integer      seed;
    int          errors;
    int          checks;
    int          t_err;
    int          t_chk;

    // model predictions for the current instruction
    logic        e_we;
    logic [4:0]  e_rd;
    logic [63:0] e_data;
    logic        e_bad;
    logic        e_ena;
    logic        e_wen;
    logic [63:0] e_addr;
    logic [63:0] e_wdata;
    logic [1:0]  e_size;
    logic [63:0] e_npc;

    rv_core dut0 (
        .clk        (clk),
        .reset      (reset),
        .inst       (inst),
        .inst_valid (inst_valid),
        .mem_ena    (mem_ena),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_size   (mem_size),
        .mem_rdata  (mem_rdata),
        .pc         (pc),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .illegal    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(total_insts * 40);
        $display("simulation timed out before all tests finished");
        $display("Test FAILED");
        $finish;
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] x);
        return {{32{x[31]}}, x};
    endfunction

    // unwritten bytes get a value folded from the whole address
    function automatic logic [7:0] mem_byte(input logic [63:0] addr);
        logic [7:0] f;
        if (mem.exists(addr))
            return mem[addr];
        f = 8'h5a;
        for (int k = 0; k < 8; k++)
            f = f ^ addr[8*k +: 8];
        return f;
    endfunction

    function automatic logic [63:0] mem_read64(input logic [63:0] addr);
        logic [63:0] v;
        for (int k = 0; k < 8; k++)
            v[8*k +: 8] = mem_byte(addr + 64'(k));
        return v;
    endfunction

    task automatic mem_write(input logic [63:0] addr, input logic [63:0] data,
                             input logic [1:0] size);
        for (int k = 0; k < (1 << size); k++)
            mem[addr + 64'(k)] = data[8*k +: 8];
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // RISC-V semantics of one instruction against the model state
    task automatic model_step(input logic [31:0] i);
        logic [6:0]         opc;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [63:0]        a;
        logic [63:0]        b;
        logic [63:0]        imm_i;
        logic [63:0]        imm_s;
        logic [63:0]        imm_b;
        logic [63:0]        imm_u;
        logic [63:0]        imm_j;
        logic [63:0]        ld;
        logic signed [31:0] x32;
        logic signed [31:0] y32;
        logic signed [31:0] q;
        logic signed [31:0] rm;
        logic [31:0]        w;
        logic               bad;
        opc   = i[6:0];
        f3    = i[14:12];
        f7    = i[31:25];
        a     = regs[i[19:15]];
        b     = regs[i[24:20]];
        imm_i = {{52{i[31]}}, i[31:20]};
        imm_s = {{52{i[31]}}, i[31:25], i[11:7]};
        imm_b = {{51{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        imm_u = {{32{i[31]}}, i[31:12], 12'b0};
        imm_j = {{43{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        bad = 1'b0;
        e_we = 1'b1;
        e_rd = i[11:7];
        e_data = '0;
        e_ena = 1'b0;
        e_wen = 1'b0;
        e_addr = '0;
        e_wdata = '0;
        e_size = '0;
        e_npc = mpc + 64'd4;
        case (opc)
            op_lui:   e_data = imm_u;
            op_auipc: e_data = mpc + imm_u;
            op_jal: begin
                e_data = mpc + 64'd4;
                e_npc  = mpc + imm_j;
            end
            op_jalr: begin
                bad    = f3 != 3'd0;
                e_data = mpc + 64'd4;
                e_npc  = (a + imm_i) & ~64'd1;
            end
            op_branch: begin
                e_we = 1'b0;
                case (f3)
                    3'd0: if (a == b) e_npc = mpc + imm_b;
                    3'd1: if (a != b) e_npc = mpc + imm_b;
                    3'd4: if ($signed(a) < $signed(b)) e_npc = mpc + imm_b;
                    3'd5: if ($signed(a) >= $signed(b)) e_npc = mpc + imm_b;
                    3'd6: if (a < b) e_npc = mpc + imm_b;
                    3'd7: if (a >= b) e_npc = mpc + imm_b;
                    default: bad = 1'b1;
                endcase
            end
            op_load: begin
                bad    = f3 == 3'd7;
                e_ena  = 1'b1;
                e_addr = a + imm_i;
                e_size = f3[1:0];
                ld     = mem_read64(e_addr);
                case (f3)
                    3'd0: e_data = {{56{ld[7]}}, ld[7:0]};
                    3'd1: e_data = {{48{ld[15]}}, ld[15:0]};
                    3'd2: e_data = sext32(ld[31:0]);
                    3'd4: e_data = {56'b0, ld[7:0]};
                    3'd5: e_data = {48'b0, ld[15:0]};
                    3'd6: e_data = {32'b0, ld[31:0]};
                    default: e_data = ld;
                endcase
            end
            op_store: begin
                bad     = f3[2];
                e_we    = 1'b0;
                e_ena   = 1'b1;
                e_wen   = 1'b1;
                e_addr  = a + imm_s;
                e_size  = f3[1:0];
                e_wdata = b;
            end
            op_imm: begin
                case (f3)
                    3'd0: e_data = a + imm_i;
                    3'd3: e_data = {63'b0, a < imm_i};
                    3'd7: e_data = a & imm_i;
                    3'd1: begin
                        bad    = i[31:26] != 6'b000000;
                        e_data = a << i[25:20];
                    end
                    3'd5: begin
                        if (i[31:26] == 6'b000000)
                            e_data = a >> i[25:20];
                        else if (i[31:26] == 6'b010000)
                            e_data = $signed(a) >>> i[25:20];
                        else
                            bad = 1'b1;
                    end
                    default: bad = 1'b1;   // slti, xori, ori not supported
                endcase
            end
            op_imm32: begin
                bad    = f3 != 3'd0;
                e_data = sext32(a[31:0] + imm_i[31:0]);
            end
            op_reg: begin
                if (f7 == 7'h00) begin
                    case (f3)
                        3'd0: e_data = a + b;
                        3'd1: e_data = a << b[5:0];
                        3'd2: e_data = {63'b0, $signed(a) < $signed(b)};
                        3'd3: e_data = {63'b0, a < b};
                        3'd4: e_data = a ^ b;
                        3'd5: e_data = a >> b[5:0];
                        3'd6: e_data = a | b;
                        default: e_data = a & b;
                    endcase
                end else if (f7 == 7'h20 && f3 == 3'd0)
                    e_data = a - b;
                else if (f7 == 7'h20 && f3 == 3'd5)
                    e_data = $signed(a) >>> b[5:0];
                else
                    bad = 1'b1;
            end
            op_reg32: begin
                x32 = a[31:0];
                y32 = b[31:0];
                // div by zero gives -1 and the dividend, overflow keeps the dividend
                if (y32 == 0) begin
                    q  = -1;
                    rm = x32;
                end else if (x32 == 32'sh8000_0000 && y32 == -1) begin
                    q  = x32;
                    rm = 0;
                end else begin
                    q  = x32 / y32;
                    rm = x32 % y32;
                end
                w = a[31:0] * b[31:0];
                if (f3 == 3'd0 && f7 == 7'h00)
                    e_data = sext32(a[31:0] + b[31:0]);
                else if (f3 == 3'd0 && f7 == 7'h20)
                    e_data = sext32(a[31:0] - b[31:0]);
                else if (f3 == 3'd0 && f7 == 7'h01)
                    e_data = sext32(w);
                else if (f3 == 3'd4 && f7 == 7'h01)
                    e_data = sext32(q);
                else if (f3 == 3'd6 && f7 == 7'h01)
                    e_data = sext32(rm);
                else
                    bad = 1'b1;
            end
            default: bad = 1'b1;
        endcase
        e_bad = bad;
        if (bad) begin
            e_we  = 1'b0;
            e_ena = 1'b0;
            e_wen = 1'b0;
            e_npc = mpc + 64'd4;
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        inst = rnd();
        inst_valid = 1'b0;
        #6;
        check(64'(wb_en), 64'd0, "wb_en in idle cycle");
        check(64'(mem_ena), 64'd0, "mem_ena in idle cycle");
        check(64'(mem_wen), 64'd0, "mem_wen in idle cycle");
        check(pc, mpc, "pc in idle cycle");
        @(posedge clk);
    endtask

    task automatic run_inst(input logic [31:0] i);
        logic [31:0] r;
        r = rnd();
        if (r[2:0] == 3'd0)
            idle_cycle();
        @(negedge clk);
        inst = i;
        inst_valid = 1'b1;
        model_step(i);
        #2 mem_rdata = mem_read64(mem_addr);
        #4;
        check(pc, mpc, "pc");
        check(64'(illegal), 64'(e_bad), "illegal");
        check(64'(wb_en), 64'(e_we), "wb_en");
        if (e_we) begin
            check(64'(wb_rd), 64'(e_rd), "wb_rd");
            check(wb_data, e_data, "wb_data");
        end
        check(64'(mem_ena), 64'(e_ena), "mem_ena");
        check(64'(mem_wen), 64'(e_wen), "mem_wen");
        if (e_ena) begin
            check(mem_addr, e_addr, "mem_addr");
            check(64'(mem_size), 64'(e_size), "mem_size");
        end
        if (e_wen)
            check(mem_wdata, e_wdata, "mem_wdata");
        @(posedge clk);
        if (e_we && e_rd != 5'd0)
            regs[e_rd] = e_data;
        if (e_wen)
            mem_write(e_addr, e_wdata, e_size);
        mpc = e_npc;
    endtask

    // x31 is the memory base, so random writes skip it
    function automatic logic [31:0] gen_alu();
        logic [31:0] r;
        logic [31:0] v;
        logic [4:0]  rd;
        logic [6:0]  f7;
        r  = rnd();
        v  = rnd();
        rd = 5'(v % 32'd31);
        v  = rnd();
        f7 = ((r[12:10] == 3'd0 || r[12:10] == 3'd5) && r[13]) ? 7'h20 : 7'h00;
        case (r[31:28])
            4'd0:  return {v[31:12], rd, op_lui};
            4'd1:  return {v[31:12], rd, op_auipc};
            4'd2:  return {v[11:0], r[4:0], 3'd0, rd, op_imm};
            4'd3:  return {v[11:0], r[4:0], 3'd3, rd, op_imm};
            4'd4:  return {v[11:0], r[4:0], 3'd7, rd, op_imm};
            4'd5:  return {6'b000000, v[5:0], r[4:0], 3'd1, rd, op_imm};
            4'd6:  return {6'b000000, v[5:0], r[4:0], 3'd5, rd, op_imm};
            4'd7:  return {6'b010000, v[5:0], r[4:0], 3'd5, rd, op_imm};
            4'd8:  return {v[11:0], r[4:0], 3'd0, rd, op_imm32};
            4'd9:  return {7'h00, r[9:5], r[4:0], 3'd0, rd, op_reg32};
            4'd10: return {7'h20, r[9:5], r[4:0], 3'd0, rd, op_reg32};
            4'd11: return {7'h01, r[9:5], r[4:0], 3'd0, rd, op_reg32};
            default: return {f7, r[9:5], r[4:0], r[12:10], rd, op_reg};
        endcase
    endfunction

    function automatic logic [31:0] gen_divrem();
        logic [31:0] r;
        logic [4:0]  rs2;
        r   = rnd();
        rs2 = (r[3:1] == 3'd0) ? 5'd0 : r[24:20];   // zero divisor now and then
        return {7'h01, rs2, r[19:15], r[0] ? 3'd6 : 3'd4, 5'(r[31:27] % 5'd31), op_reg32};
    endfunction

    function automatic logic [31:0] gen_mem();
        logic [31:0] r;
        logic [31:0] v;
        logic [2:0]  f3;
        logic [11:0] off;
        r   = rnd();
        v   = rnd();
        f3  = (r[31:29] == 3'd7) ? 3'd3 : r[31:29];
        off = {6'b0, v[5:0]} & (12'hfff << f3[1:0]);   // aligned, small window
        if (r[0])
            return {off[11:5], r[9:5], 5'd31, 1'b0, f3[1:0], off[4:0], op_store};
        return {off, 5'd31, f3, 5'(v % 32'd31), op_load};
    endfunction

    function automatic logic [31:0] gen_ctrl();
        logic [31:0] r;
        logic [31:0] v;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [4:0]  rs2;
        r   = rnd();
        v   = rnd();
        rd  = 5'(r[31:10] % 22'd31);
        f3  = v[31:29];
        if (f3[2:1] == 2'b01)
            f3[1] = 1'b0;
        rs2 = r[2] ? r[9:5] : r[14:10];
        case (r[1:0])
            2'd0: return {v[20], v[10:2], 1'b0, v[11], v[19:12], rd, op_jal};
            2'd1: return {v[11:2], 2'b00, 5'd31, 3'd0, rd, op_jalr};
            default: return {v[12], v[10:5], rs2, r[9:5], f3, v[4:2], 1'b0, v[11], op_branch};
        endcase
    endfunction

    // near misses of loads, stores, branches and jalr besides plain bad words
    function automatic logic [31:0] gen_bad();
        logic [31:0] r;
        logic [31:0] v;
        r = rnd();
        v = rnd();
        case (r[2:0])
            3'd0: return {v[31:15], 3'd2, v[11:7], op_imm};
            3'd1: return {v[31:20], 5'd31, 3'd7, v[11:7], op_load};
            3'd2: return {v[31:20], 5'd31, 1'b1, v[13:12], v[11:7], op_store};
            3'd3: return {v[31:15], 2'b01, v[12], v[11:7], op_branch};
            3'd4: return {v[31:15], v[14:13], 1'b1, v[11:7], op_jalr};
            default: return {v[31:7], 7'h7f};
        endcase
    endfunction

    // about one in twenty random words is illegal
    function automatic logic [31:0] pick(input int cls);
        logic [31:0] r;
        r = rnd();
        if (r % 32'd20 == 32'd0)
            return gen_bad();
        case (cls)
            1: return gen_divrem();
            2: return gen_mem();
            3: return gen_ctrl();
            default: return gen_alu();
        endcase
    endfunction

    task automatic start_test();
        t_err = errors;
        t_chk = checks;
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - t_chk, errors - t_err);
    endtask

    initial begin
        seed = 32'h0c884fa0;
        errors = 0;
        checks = 0;
        reset = 1'b1;
        inst = '0;
        inst_valid = 1'b0;
        mem_rdata = '0;
        for (int k = 0; k < 32; k++)
            regs[k] = '0;
        mpc = reset_pc;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_test();
        #1 check(pc, reset_pc, "pc after reset");
        for (int k = 1; k < 32; k++)
            run_inst({7'h00, 5'(k % 31 + 1), 5'(k), 3'd0, 5'(k), op_reg});
        end_test("reset");

        run_inst({20'h00010, 5'd31, op_lui});   // memory base

        start_test();
        repeat (n_alu) run_inst(pick(0));
        end_test("alu and immediate");

        start_test();
        run_inst({20'h80000, 5'd1, op_lui});
        run_inst({12'hfff, 5'd0, 3'd0, 5'd2, op_imm});
        run_inst({12'h000, 5'd0, 3'd0, 5'd3, op_imm});
        run_inst({7'h01, 5'd2, 5'd1, 3'd4, 5'd4, op_reg32});
        run_inst({7'h01, 5'd2, 5'd1, 3'd6, 5'd5, op_reg32});
        run_inst({7'h01, 5'd3, 5'd1, 3'd4, 5'd6, op_reg32});
        run_inst({7'h01, 5'd3, 5'd1, 3'd6, 5'd7, op_reg32});
        repeat (n_div) run_inst(pick(1));
        end_test("divw and remw");

        start_test();
        repeat (n_mem) run_inst(pick(2));
        end_test("loads and stores");

        start_test();
        repeat (n_ctrl) run_inst(pick(3));
        end_test("control flow");

        start_test();
        repeat (n_bad) run_inst((rnd() % 32'd3 == 32'd0) ? gen_bad() : gen_alu());
        @(negedge clk);
        inst_valid = 1'b0;
        #6 check(pc, mpc, "final pc");
        end_test("illegal and idle");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* build.f */
src/rv_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
bench/rv_core_sva.sv
bench/tb_core.sv

/* Makefile */
TOP = tb_core

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench, log in sim.log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

.PHONY: help test clean
